/* rtl/rv_isa_pkg.sv */
package rv_isa_pkg;

	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_AUIPC  = 7'b0010111;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_JALR   = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_OP_IMM = 7'b0010011;
	localparam logic [6:0] OP_OP     = 7'b0110011;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi; // imm[11:5]
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo; // imm[4:0]
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm; // imm[31:12]
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
	} instr_u;

	typedef enum logic [2:0] {
		cls_none,
		cls_upper,
		cls_jump,
		cls_alu_reg,
		cls_alu_imm,
		cls_load,
		cls_store,
		cls_branch
	} instr_class_e;

endpackage

/* rtl/issue_pkg.sv */
package issue_pkg;

	localparam int ISSUE_STALL_W = 4; // stall count port width

	typedef struct packed {
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [4:0] rd;
		logic       uses_rs1;
		logic       uses_rs2;
		logic       writes_rd;
	} reg_use_t;

	typedef struct packed {
		rv_isa_pkg::instr_u       instr;
		rv_isa_pkg::instr_class_e cls;
		logic [4:0]               rd;
	} issue_rec_t;

endpackage

/* rtl/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder (
	input  rv_isa_pkg::instr_u       instr,
	output rv_isa_pkg::instr_class_e cls,
	output issue_pkg::reg_use_t      reg_use
);

	import rv_isa_pkg::*;
	import issue_pkg::*;

	always_comb
	begin
		cls     = cls_none;
		reg_use = '0; // unknown opcodes touch no registers
		case (instr.r.opcode)
			OP_LUI, OP_AUIPC:
			begin
				cls               = cls_upper;
				reg_use.rd        = instr.u.rd;
				reg_use.writes_rd = 1'b1;
			end
			OP_JAL:
			begin
				cls               = cls_jump;
				reg_use.rd        = instr.u.rd;
				reg_use.writes_rd = 1'b1;
			end
			OP_JALR:
			begin
				cls               = cls_jump;
				reg_use.rs1       = instr.i.rs1;
				reg_use.rd        = instr.i.rd;
				reg_use.uses_rs1  = 1'b1;
				reg_use.writes_rd = 1'b1;
			end
			OP_OP:
			begin
				cls               = cls_alu_reg;
				reg_use.rs1       = instr.r.rs1;
				reg_use.rs2       = instr.r.rs2;
				reg_use.rd        = instr.r.rd;
				reg_use.uses_rs1  = 1'b1;
				reg_use.uses_rs2  = 1'b1;
				reg_use.writes_rd = 1'b1;
			end
			OP_OP_IMM, OP_LOAD:
			begin
				cls               = (instr.i.opcode == OP_LOAD) ? cls_load : cls_alu_imm;
				reg_use.rs1       = instr.i.rs1; // rs2 bits are immediate here
				reg_use.rd        = instr.i.rd;
				reg_use.uses_rs1  = 1'b1;
				reg_use.writes_rd = 1'b1;
			end
			OP_STORE:
			begin
				cls              = cls_store;
				reg_use.rs1      = instr.s.rs1;
				reg_use.rs2      = instr.s.rs2;
				reg_use.uses_rs1 = 1'b1;
				reg_use.uses_rs2 = 1'b1;
			end
			OP_BRANCH:
			begin
				cls              = cls_branch;
				reg_use.rs1      = instr.b.rs1;
				reg_use.rs2      = instr.b.rs2;
				reg_use.uses_rs1 = 1'b1;
				reg_use.uses_rs2 = 1'b1;
			end
			default:
			begin
				cls = cls_none;
			end
		endcase
	end

endmodule

/* rtl/reg_scoreboard.sv */
`timescale 1ns/1ps

module reg_scoreboard #(
	parameter int WB_LATENCY = 3
) (
	input  logic                                  clk,
	input  logic                                  nrst,
	input  logic                                  in_valid,
	input  rv_isa_pkg::instr_u                    in_instr,
	input  rv_isa_pkg::instr_class_e              cls,
	input  issue_pkg::reg_use_t                   reg_use,
	input  logic                                  flushing,
	output logic                                  in_ready,
	output logic                                  accept,
	output logic [issue_pkg::ISSUE_STALL_W-1:0]   stall_cycles,
	output logic                                  out_valid,
	output issue_pkg::issue_rec_t                 out_rec
);

	import issue_pkg::*;

	localparam int STALL_MAX = 2**ISSUE_STALL_W - 1;
	localparam int LOAD_RAW  = WB_LATENCY - 1;
	// count holds the edges a reader still has to wait
	localparam logic [ISSUE_STALL_W-1:0] LOAD_CNT =
		(LOAD_RAW > STALL_MAX) ? ISSUE_STALL_W'(STALL_MAX) : ISSUE_STALL_W'(LOAD_RAW);

	logic [ISSUE_STALL_W-1:0] cnt [1:31]; // x0 never pending
	logic [ISSUE_STALL_W-1:0] rs1_cnt;
	logic [ISSUE_STALL_W-1:0] rs2_cnt;
	logic [ISSUE_STALL_W-1:0] wait_cnt;
	logic                     hazard;
	logic                     issue;

	always_comb
	begin
		rs1_cnt = '0;
		rs2_cnt = '0;
		if (reg_use.uses_rs1 && reg_use.rs1 != 5'd0)
			rs1_cnt = cnt[reg_use.rs1];
		if (reg_use.uses_rs2 && reg_use.rs2 != 5'd0)
			rs2_cnt = cnt[reg_use.rs2];
		wait_cnt = (rs1_cnt > rs2_cnt) ? rs1_cnt : rs2_cnt;
	end

	assign hazard       = (wait_cnt != '0);
	assign in_ready     = flushing || !in_valid || !hazard; // wrong path never waits
	assign accept       = in_valid && in_ready;
	assign issue        = accept && !flushing;
	assign stall_cycles = (in_valid && !in_ready) ? wait_cnt : '0;

	genvar r;
	generate
		for (r = 1; r < 32; r++)
		begin : g_cnt
			always_ff @(posedge clk, negedge nrst)
			begin
				if (!nrst)
					cnt[r] <= '0;
				else if (issue && reg_use.writes_rd && reg_use.rd == 5'(r))
					cnt[r] <= LOAD_CNT;
				else if (cnt[r] != '0)
					cnt[r] <= cnt[r] - 1'b1;
			end
		end
	endgenerate

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			out_valid <= 1'b0;
		else
			out_valid <= issue;
	end

	always_ff @(posedge clk)
	begin
		if (issue)
		begin
			out_rec.instr <= in_instr;
			out_rec.cls   <= cls;
			out_rec.rd    <= reg_use.rd;
		end
	end

endmodule

/* rtl/flush_ctrl.sv */
`timescale 1ns/1ps

module flush_ctrl #(
	parameter int FLUSH_CYCLES = 2
) (
	input  logic clk,
	input  logic nrst,
	input  logic branch_taken,
	input  logic accept,
	output logic flushing
);

	localparam int CNT_W = (FLUSH_CYCLES > 0) ? $clog2(FLUSH_CYCLES + 1) : 1;

	logic [CNT_W-1:0] drop_cnt; // transfers still to drop

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			drop_cnt <= '0;
		else if (branch_taken)
			drop_cnt <= CNT_W'(FLUSH_CYCLES); // reload even mid window
		else if (accept && drop_cnt != '0)
			drop_cnt <= drop_cnt - 1'b1;
	end

	assign flushing = (drop_cnt != '0);

endmodule

/* rtl/issue_stage.sv */
`timescale 1ns/1ps

module issue_stage #(
	parameter int WB_LATENCY   = 3,
	parameter int FLUSH_CYCLES = 2
) (
	input  logic                                clk,
	input  logic                                nrst,
	input  logic                                in_valid,
	input  rv_isa_pkg::instr_u                  in_instr,
	input  logic                                branch_taken,
	output logic                                in_ready,
	output logic [issue_pkg::ISSUE_STALL_W-1:0] stall_cycles,
	output logic                                out_valid,
	output issue_pkg::issue_rec_t               out_rec
);

	import rv_isa_pkg::*;
	import issue_pkg::*;

	instr_class_e dec_cls;
	reg_use_t     dec_use;
	logic         flushing;
	logic         accept;

	instr_decoder i_decoder (
		.instr   (in_instr),
		.cls     (dec_cls),
		.reg_use (dec_use)
	);

	reg_scoreboard #(
		.WB_LATENCY (WB_LATENCY)
	) i_scoreboard (
		.clk          (clk),
		.nrst         (nrst),
		.in_valid     (in_valid),
		.in_instr     (in_instr),
		.cls          (dec_cls),
		.reg_use      (dec_use),
		.flushing     (flushing),
		.in_ready     (in_ready),
		.accept       (accept),
		.stall_cycles (stall_cycles),
		.out_valid    (out_valid),
		.out_rec      (out_rec)
	);

	flush_ctrl #(
		.FLUSH_CYCLES (FLUSH_CYCLES)
	) i_flush (
		.clk          (clk),
		.nrst         (nrst),
		.branch_taken (branch_taken),
		.accept       (accept),
		.flushing     (flushing)
	);

endmodule

/* testbench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic nrst
);

	initial
	begin
		clk  = 1'b0;
		nrst = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		nrst = 1'b1;
	end

	always #50 clk = ~clk; // 100 ns period

endmodule

/* testbench/tb_issue_stage.sv */
`timescale 1ns/1ps

module tb_issue_stage;

	import rv_isa_pkg::*;
	import issue_pkg::*;

	localparam int WB_LATENCY   = 3;
	localparam int FLUSH_CYCLES = 2;

	logic                     clk;
	logic                     nrst;
	logic                     in_valid;
	instr_u                   in_instr;
	logic                     branch_taken;
	logic                     in_ready;
	logic [ISSUE_STALL_W-1:0] stall_cycles;
	logic                     out_valid;
	issue_rec_t               out_rec;

	// reference model state
	int         m_cnt [0:31];
	int         m_flush;
	bit         m_out;
	issue_rec_t rec_q [$];
	int         cycle;
	int         xfer_count;
	int         accept_cycle;
	int         issue_count;
	int         out_count; // out_valid pulses seen on the DUT
	logic [31:0] lcg_state = 32'h43e55929;

	tb_clock i_clock (
		.clk  (clk),
		.nrst (nrst)
	);

	issue_stage i_dut (
		.clk          (clk),
		.nrst         (nrst),
		.in_valid     (in_valid),
		.in_instr     (in_instr),
		.branch_taken (branch_taken),
		.in_ready     (in_ready),
		.stall_cycles (stall_cycles),
		.out_valid    (out_valid),
		.out_rec      (out_rec)
	);

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic value_error(input string name, input logic [63:0] exp, input logic [63:0] got);
		fail_run($sformatf("** Error: %s expected 0x%0h got 0x%0h", name, exp, got));
	endtask

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [31:0] encode(input logic [6:0] op, input int rd, input int rs1,
		input int rs2);
		return {7'h00, 5'(rs2), 5'(rs1), 3'h0, 5'(rd), op};
	endfunction

	// register usage per the ISA rules
	task automatic usage(input logic [31:0] w, output bit r1, output bit r2, output bit wr,
		output instr_class_e c);
		case (w[6:0])
			OP_LUI, OP_AUIPC: c = cls_upper;
			OP_JAL, OP_JALR:  c = cls_jump;
			OP_OP:            c = cls_alu_reg;
			OP_OP_IMM:        c = cls_alu_imm;
			OP_LOAD:          c = cls_load;
			OP_STORE:         c = cls_store;
			OP_BRANCH:        c = cls_branch;
			default:          c = cls_none;
		endcase
		r2 = (c inside {cls_alu_reg, cls_store, cls_branch});
		r1 = r2 || (c inside {cls_alu_imm, cls_load}) || (w[6:0] == OP_JALR);
		wr = (c inside {cls_upper, cls_jump, cls_alu_reg, cls_alu_imm, cls_load});
	endtask

	always @(posedge clk)
	begin
		bit           r1;
		bit           r2;
		bit           wr;
		instr_class_e c;
		int           wait_c;
		int           exp_stall;
		bit           exp_ready;
		bit           acc;
		bit           iss;
		issue_rec_t   exp_rec;
		logic [31:0]  w;
		if (!nrst)
		begin
			foreach (m_cnt[r])
				m_cnt[r] = 0;
			m_flush = 0;
			m_out   = 0;
			rec_q.delete();
		end
		else
		begin
			w = in_instr;
			usage(w, r1, r2, wr, c);
			wait_c = 0;
			if (r1 && m_cnt[w[19:15]] > wait_c)
				wait_c = m_cnt[w[19:15]];
			if (r2 && m_cnt[w[24:20]] > wait_c)
				wait_c = m_cnt[w[24:20]];
			exp_ready = (m_flush != 0) || !in_valid || (wait_c == 0);
			exp_stall = (in_valid && !exp_ready) ? ((wait_c > 15) ? 15 : wait_c) : 0;
			assert (in_ready === exp_ready)
				else value_error("in_ready", 64'(exp_ready), 64'(in_ready));
			assert (stall_cycles === 4'(exp_stall))
				else value_error("stall_cycles", 64'(exp_stall), 64'(stall_cycles));
			assert (out_valid === m_out)
				else value_error("out_valid", 64'(m_out), 64'(out_valid));
			if (out_valid === 1'b1)
				out_count++;
			if (m_out)
			begin
				exp_rec = rec_q.pop_front();
				assert (out_rec === exp_rec)
					else value_error("out_rec", 64'(exp_rec), 64'(out_rec));
			end
			acc = in_valid && exp_ready;
			iss = acc && (m_flush == 0);
			for (int r = 1; r < 32; r++)
				if (m_cnt[r] > 0)
					m_cnt[r]--;
			if (iss)
			begin
				if (wr && w[11:7] != 5'd0)
					m_cnt[w[11:7]] = WB_LATENCY - 1; // waits left for a reader
				exp_rec.instr = w;
				exp_rec.cls   = c;
				exp_rec.rd    = wr ? w[11:7] : 5'd0;
				rec_q.push_back(exp_rec);
				issue_count++;
			end
			if (branch_taken)
				m_flush = FLUSH_CYCLES;
			else if (acc && m_flush > 0)
				m_flush--;
			m_out = iss;
			cycle++;
			if (acc)
			begin
				xfer_count++;
				accept_cycle = cycle;
			end
		end
	end

	// entered just after a falling edge, returns on one
	task automatic send(input logic [31:0] w, output int t);
		int n0;
		int i;
		in_valid     = 1'b1;
		in_instr     = w;
		branch_taken = 1'b0;
		n0 = xfer_count;
		for (i = 0; i < 50; i++)
		begin
			@(negedge clk);
			if (xfer_count != n0)
				break;
		end
		if (xfer_count == n0)
			fail_run("timeout: instruction was never accepted");
		t = accept_cycle;
	endtask

	task automatic idle(input int n);
		in_valid     = 1'b0;
		branch_taken = 1'b0;
		repeat (n) @(negedge clk);
	endtask

	task automatic pulse_branch();
		in_valid     = 1'b0;
		branch_taken = 1'b1;
		@(negedge clk);
		branch_taken = 1'b0;
	endtask

	task automatic expect_gap(input int t0, input int t1, input int gap, input string what);
		if (t1 - t0 != gap)
			fail_run($sformatf("%s accepted %0d cycles after the earlier one, wanted %0d",
				what, t1 - t0, gap));
	endtask

	initial
	begin
		int t0;
		int t1;
		int n_out;
		int i;
		logic [6:0] ops [10];
		logic [31:0] r;
		in_valid     = 1'b0;
		in_instr     = '0;
		branch_taken = 1'b0;
		ops = '{OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_BRANCH, OP_LOAD, OP_STORE,
			OP_OP_IMM, OP_OP, 7'b1110011};
		for (i = 0; i < 20 && nrst !== 1'b1; i++)
			@(posedge clk);
		if (nrst !== 1'b1)
			fail_run("timeout: reset never released");
		@(negedge clk);
		assert (out_valid === 1'b0)
			else value_error("out_valid", 64'h0, 64'(out_valid));
		assert (in_ready === 1'b1)
			else value_error("in_ready", 64'h1, 64'(in_ready));
		assert (stall_cycles === '0)
			else value_error("stall_cycles", 64'h0, 64'(stall_cycles));

		// independent stream, one per cycle
		send(encode(OP_OP, 1, 11, 21), t0);
		for (i = 2; i < 9; i++)
		begin
			send(encode(OP_OP, i, i + 10, i + 20), t1);
			expect_gap(t0, t1, 1, "independent instruction");
			t0 = t1;
		end
		idle(4);

		// read after write
		send(encode(OP_OP_IMM, 5, 0, 0), t0);
		send(encode(OP_OP, 6, 5, 0), t1);
		expect_gap(t0, t1, WB_LATENCY, "dependent instruction");
		send(encode(OP_STORE, 0, 1, 6), t1);
		idle(4);

		// no false hazards
		send(encode(OP_OP_IMM, 0, 3, 0), t0);
		send(encode(OP_OP, 4, 0, 0), t1);
		expect_gap(t0, t1, 1, "reader of x0");
		send(encode(OP_STORE, 7, 1, 2), t0);
		send(encode(OP_BRANCH, 8, 1, 2), t1);
		send(encode(OP_OP, 9, 7, 8), t1);
		expect_gap(t0, t1, 2, "reader after store and branch");
		idle(4);
		send(encode(OP_OP_IMM, 10, 0, 0), t0);
		send(encode(OP_OP_IMM, 11, 0, 10), t1);
		expect_gap(t0, t1, 1, "op_imm with rs2 bits");
		send(encode(OP_LOAD, 12, 0, 10), t1);
		expect_gap(t0, t1, 2, "load with rs2 bits");
		idle(4);

		// flush window and reload
		pulse_branch();
		n_out = out_count;
		send(encode(OP_OP_IMM, 13, 0, 0), t0);
		send(encode(OP_OP_IMM, 13, 0, 0), t0);
		send(encode(OP_OP, 14, 13, 13), t1);
		expect_gap(t0, t1, 1, "reader of a flushed rd");
		assert (out_count == n_out) else fail_run("flushed instruction was issued");
		idle(2);
		pulse_branch();
		send(encode(OP_OP_IMM, 15, 0, 0), t0);
		pulse_branch();
		n_out = out_count;
		for (i = 0; i < FLUSH_CYCLES; i++)
			send(encode(OP_OP_IMM, 15, 0, 0), t0);
		idle(4);
		assert (out_count == n_out) else fail_run("reloaded window did not drop");

		// random mixed stream
		for (i = 0; i < 300; i++)
		begin
			r = lcg_next();
			if (r[17:16] == 2'd3)
			begin
				in_valid     = 1'b0;
				branch_taken = (r[27:24] == 4'd0);
				@(negedge clk);
			end
			r = lcg_next();
			send(encode(ops[r[31:16] % 10], r[20:18], r[23:21], r[26:24]), t0);
		end
		idle(6);

		if (out_count == issue_count)
		begin
			$display("All tests passed!");
			$finish;
		end
		else
			fail_run("number of issued records differs from the model");
	end

endmodule

/* vlog.f */
rtl/rv_isa_pkg.sv
rtl/issue_pkg.sv
rtl/instr_decoder.sv
rtl/reg_scoreboard.sv
rtl/flush_ctrl.sv
rtl/issue_stage.sv
testbench/tb_clock.sv
testbench/tb_issue_stage.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_issue_stage -o sim_issue

./obj_dir/sim_issue > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed!" sim.log; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed"
exit 1
